// ==== design/fat_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the fat32 file reader
// only fat32 with 512 byte sectors is handled
// short 8.3 names only, no long file name support
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fat_pkg;

    localparam int sector_bytes           = 512;
    localparam int dir_entry_bytes        = 32;
    localparam int short_name_bytes       = 11;
    localparam int fat_entries_per_sector = 128;    // 4-byte entries in one sector
    localparam logic [27:0] end_of_chain  = 28'h0FFFFF8;

    typedef logic [31:0] sector_t;
    typedef logic [31:0] cluster_t;

    // one byte from the block device
    typedef struct packed {
        logic       valid;
        logic [8:0] offset;     // byte position in the sector
        logic [7:0] data;
    } sector_beat_t;

    typedef struct packed {
        logic        sig_ok;    // 55 aa at the sector end
        logic        is_vbr;    // jump byte eb or e9
        sector_t     part_start;            // first partition entry lba
        logic [15:0] bytes_per_sector;
        logic [7:0]  sectors_per_cluster;
        logic [15:0] reserved_sectors;
        logic [7:0]  fat_count;
        logic [31:0] sectors_per_fat;
        cluster_t    root_cluster;
        logic        fat32_marker;
    } boot_fields_t;

    typedef struct packed {
        logic        found;
        cluster_t    first_cluster;
        logic [31:0] size;
    } file_hit_t;

    typedef enum logic [2:0] {
        IDLE,
        FIND_MBR,
        FIND_VBR,
        LIST_ROOT,
        READ_FILE,
        DONE
    } walk_state_e;

endpackage

`default_nettype wire

// ==== design/boot_sector_parser.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks boot record fields out of every sector that passes
// fields are valid only after the whole sector has streamed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module boot_sector_parser (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fat_pkg::sector_beat_t beat,
    output fat_pkg::boot_fields_t fields
);

    logic             sig_lo_ok;    // byte 0x1fe was 55
    logic             sig_ok;
    logic             is_vbr;
    logic             fat32_marker;
    fat_pkg::sector_t part_start;
    logic [15:0]      bytes_per_sector;
    logic [7:0]       sectors_per_cluster;
    logic [15:0]      reserved_sectors;
    logic [7:0]       fat_count;
    logic [31:0]      sectors_per_fat;
    fat_pkg::cluster_t root_cluster;
    logic [1:0]       part_byte;

    // partition lba sits at 0x1c6 which is not word aligned
    assign part_byte = beat.offset[1:0] - 2'd2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sig_lo_ok    <= 1'b0;
            sig_ok       <= 1'b0;
            is_vbr       <= 1'b0;
            fat32_marker <= 1'b0;
        end else if (beat.valid) begin
            case (beat.offset)
                9'h000: is_vbr <= (beat.data == 8'hEB) || (beat.data == 8'hE9);
                9'h056: fat32_marker <= (beat.data == 8'h32);  // the '2' of "FAT32   "
                9'h1FE: sig_lo_ok <= (beat.data == 8'h55);
                9'h1FF: sig_ok <= sig_lo_ok && (beat.data == 8'hAA);
                default: ;
            endcase
        end
    end

    // little-endian bpb fields
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            case (beat.offset)
                9'h00B: bytes_per_sector[7:0]  <= beat.data;
                9'h00C: bytes_per_sector[15:8] <= beat.data;
                9'h00D: sectors_per_cluster    <= beat.data;
                9'h00E: reserved_sectors[7:0]  <= beat.data;
                9'h00F: reserved_sectors[15:8] <= beat.data;
                9'h010: fat_count              <= beat.data;
                9'h024, 9'h025, 9'h026, 9'h027:
                    sectors_per_fat[8*beat.offset[1:0] +: 8] <= beat.data;
                9'h02C, 9'h02D, 9'h02E, 9'h02F:
                    root_cluster[8*beat.offset[1:0] +: 8] <= beat.data;
                9'h1C6, 9'h1C7, 9'h1C8, 9'h1C9:
                    part_start[8*part_byte +: 8] <= beat.data;
                default: ;
            endcase
        end
    end

    assign fields = '{
        sig_ok:              sig_ok,
        is_vbr:              is_vbr,
        part_start:          part_start,
        bytes_per_sector:    bytes_per_sector,
        sectors_per_cluster: sectors_per_cluster,
        reserved_sectors:    reserved_sectors,
        fat_count:           fat_count,
        sectors_per_fat:     sectors_per_fat,
        root_cluster:        root_cluster,
        fat32_marker:        fat32_marker
    };

endmodule

`default_nettype wire

// ==== design/dir_entry_matcher.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matches 32-byte directory entries against one 8.3 name
// target_name must be upper case and space padded to 11 bytes
// the first match is kept until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module dir_entry_matcher #(
    parameter logic [8*fat_pkg::short_name_bytes-1:0] target_name = "DATA    BIN"
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fat_pkg::sector_beat_t beat,
    input  logic                  dir_phase,
    output fat_pkg::file_hit_t    hit
);

    logic [4:0]        eo;              // offset inside the entry
    logic              take;
    logic [7:0]        want;            // expected name byte at eo
    logic              name_ok;         // entry still a candidate
    logic              found;
    fat_pkg::cluster_t entry_cluster;
    logic [23:0]       entry_size_lo;
    fat_pkg::cluster_t hit_cluster;
    logic [31:0]       hit_size;

    assign eo   = 5'(beat.offset % fat_pkg::dir_entry_bytes);
    assign take = beat.valid && dir_phase;
    assign want = 8'(target_name >> (8 * (fat_pkg::short_name_bytes - 1 - eo)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            name_ok <= 1'b0;
            found   <= 1'b0;
        end else if (take) begin
            if (eo == 5'd0) begin
                // 00 marks an empty slot and e5 a deleted one
                name_ok <= (beat.data == want) && (beat.data != 8'h00)
                           && (beat.data != 8'hE5);
            end else if (eo < 5'(fat_pkg::short_name_bytes)) begin
                name_ok <= name_ok && (beat.data == want);
            end else if (eo == 5'd11) begin
                name_ok <= name_ok && ((beat.data & 8'h18) == 8'h00);  // label or subdir
            end else if (eo == 5'd31 && name_ok) begin
                found <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (eo)
                5'h14, 5'h15: entry_cluster[16 + 8*eo[0] +: 8] <= beat.data;  // high word
                5'h1A, 5'h1B: entry_cluster[8*eo[0] +: 8] <= beat.data;
                5'h1C, 5'h1D, 5'h1E: entry_size_lo[8*eo[1:0] +: 8] <= beat.data;
                5'h1F: begin
                    if (name_ok && !found) begin
                        hit_cluster <= entry_cluster;
                        hit_size    <= {beat.data, entry_size_lo};
                    end
                end
                default: ;
            endcase
        end
    end

    assign hit = '{found: found, first_cluster: hit_cluster, size: hit_size};

endmodule

`default_nettype wire

// ==== design/cluster_walker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sector read sequencer for the fat32 reader
// one read in flight, decisions are taken only at read_done
// volumes other than fat32 with 512 byte sectors end in DONE
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cluster_walker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fat_pkg::sector_beat_t beat,
    input  logic                  read_done,
    input  fat_pkg::boot_fields_t fields,
    input  fat_pkg::file_hit_t    hit,
    output logic                  read_start,
    output fat_pkg::sector_t      read_sector,
    output logic                  dir_phase,
    output logic                  data_phase,
    output fat_pkg::walk_state_e  state,
    output logic                  volume_ok
);

    logic              issue;           // read_start follows one cycle later
    logic              fat_pending;     // the read in flight is a fat sector
    fat_pkg::cluster_t cur_cluster;
    logic [7:0]        sec_in_clus;
    logic [7:0]        spc;
    fat_pkg::sector_t  first_fat;
    fat_pkg::sector_t  first_data;      // where cluster 0 would start
    logic [31:0]       fat_entry;
    logic              geo_ok;
    fat_pkg::sector_t  geo_fat;
    fat_pkg::sector_t  geo_data;

    function automatic fat_pkg::sector_t cluster_sector(input fat_pkg::sector_t base,
                                                       input logic [7:0] per_cluster,
                                                       input fat_pkg::cluster_t c);
        return base + c * {24'd0, per_cluster};
    endfunction

    function automatic logic chain_end(input fat_pkg::cluster_t c);
        return (c[27:0] >= fat_pkg::end_of_chain) || (c[27:0] < 28'd2);
    endfunction

    // read_sector still holds the boot sector number here
    assign geo_ok   = fields.sig_ok && fields.is_vbr && fields.fat32_marker
                      && (fields.bytes_per_sector == 16'(fat_pkg::sector_bytes))
                      && (fields.sectors_per_cluster != 8'd0);
    assign geo_fat  = read_sector + {16'd0, fields.reserved_sectors};
    assign geo_data = geo_fat + fields.sectors_per_fat * {24'd0, fields.fat_count}
                      - {23'd0, fields.sectors_per_cluster, 1'b0};

    assign dir_phase  = (state == fat_pkg::LIST_ROOT) && !fat_pending;
    assign data_phase = (state == fat_pkg::READ_FILE) && !fat_pending;

    // grab the 4-byte entry of cur_cluster from the fat sector
    always_ff @(posedge clk) begin
        if (beat.valid && fat_pending
                && beat.offset[8:2] == 7'(cur_cluster % fat_pkg::fat_entries_per_sector)) begin
            fat_entry[8*beat.offset[1:0] +: 8] <= beat.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= fat_pkg::IDLE;
            read_start  <= 1'b0;
            issue       <= 1'b0;
            fat_pending <= 1'b0;
            volume_ok   <= 1'b0;
            read_sector <= '0;
            cur_cluster <= '0;
            sec_in_clus <= '0;
            spc         <= '0;
            first_fat   <= '0;
            first_data  <= '0;
        end else begin
            read_start <= issue;
            issue      <= 1'b0;
            case (state)
                fat_pkg::IDLE: begin
                    state       <= fat_pkg::FIND_MBR;
                    read_sector <= '0;
                    issue       <= 1'b1;
                end
                fat_pkg::FIND_MBR, fat_pkg::FIND_VBR: begin
                    if (read_done) begin
                        if (state == fat_pkg::FIND_MBR && fields.sig_ok && !fields.is_vbr
                                && fields.part_start != '0) begin
                            state       <= fat_pkg::FIND_VBR;
                            read_sector <= fields.part_start;
                            issue       <= 1'b1;
                        end else if (geo_ok) begin   // sector 0 may itself be the vbr
                            volume_ok   <= 1'b1;
                            spc         <= fields.sectors_per_cluster;
                            first_fat   <= geo_fat;
                            first_data  <= geo_data;
                            cur_cluster <= fields.root_cluster;
                            sec_in_clus <= '0;
                            read_sector <= cluster_sector(geo_data, fields.sectors_per_cluster,
                                                          fields.root_cluster);
                            state       <= fat_pkg::LIST_ROOT;
                            issue       <= 1'b1;
                        end else begin
                            state <= fat_pkg::DONE;
                        end
                    end
                end
                fat_pkg::LIST_ROOT, fat_pkg::READ_FILE: begin
                    if (read_done) begin
                        issue <= 1'b1;
                        if (fat_pending) begin
                            fat_pending <= 1'b0;
                            sec_in_clus <= '0;
                            if (chain_end(fat_entry)) begin
                                state <= fat_pkg::DONE;
                                issue <= 1'b0;
                            end else begin
                                cur_cluster <= {4'd0, fat_entry[27:0]};
                                read_sector <= cluster_sector(first_data, spc,
                                                              {4'd0, fat_entry[27:0]});
                            end
                        end else if (state == fat_pkg::LIST_ROOT && hit.found) begin
                            sec_in_clus <= '0;
                            if (chain_end(hit.first_cluster)) begin   // empty file
                                state <= fat_pkg::DONE;
                                issue <= 1'b0;
                            end else begin
                                cur_cluster <= hit.first_cluster;
                                read_sector <= cluster_sector(first_data, spc,
                                                              hit.first_cluster);
                                state       <= fat_pkg::READ_FILE;
                            end
                        end else if (sec_in_clus != spc - 8'd1) begin
                            sec_in_clus <= sec_in_clus + 8'd1;
                            read_sector <= read_sector + 32'd1;
                        end else begin
                            // cluster used up, look up the next one
                            fat_pending <= 1'b1;
                            read_sector <= first_fat
                                           + cur_cluster / fat_pkg::fat_entries_per_sector;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/file_byte_stream.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forwards file data bytes, cut off at the directory size
// no back-pressure, every outreq is one byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module file_byte_stream (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fat_pkg::sector_beat_t beat,
    input  logic                  data_phase,
    input  logic [31:0]           file_size,
    output logic                  outreq,
    output logic [7:0]            outbyte
);

    logic [31:0] sent;      // bytes forwarded so far
    logic        take;

    assign take = beat.valid && data_phase && (sent < file_size);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outreq <= 1'b0;
            sent   <= '0;
        end else begin
            outreq <= take;
            if (take)
                sent <= sent + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            outbyte <= beat.data;
    end

endmodule

`default_nettype wire

// ==== design/fat32_file_reader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reads one short-named file from a fat32 block device
// device must send 512 beats then read_done per read_start
// one file per reset, bytes come out as plain strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fat32_file_reader #(
    parameter logic [8*fat_pkg::short_name_bytes-1:0] target_name = "DATA    BIN"
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  read_done,
    input  fat_pkg::sector_beat_t beat,
    output logic                  read_start,
    output fat_pkg::sector_t      read_sector,
    output fat_pkg::walk_state_e  state,
    output logic                  volume_ok,
    output logic                  file_found,
    output logic                  outreq,
    output logic [7:0]            outbyte
);

    fat_pkg::boot_fields_t fields;
    fat_pkg::file_hit_t    hit;
    logic                  dir_phase;
    logic                  data_phase;

    assign file_found = hit.found;

    boot_sector_parser boot_sector_parser_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .beat   (beat),
        .fields (fields)
    );

    dir_entry_matcher #(
        .target_name (target_name)
    ) dir_entry_matcher_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat      (beat),
        .dir_phase (dir_phase),
        .hit       (hit)
    );

    cluster_walker cluster_walker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat        (beat),
        .read_done   (read_done),
        .fields      (fields),
        .hit         (hit),
        .read_start  (read_start),
        .read_sector (read_sector),
        .dir_phase   (dir_phase),
        .data_phase  (data_phase),
        .state       (state),
        .volume_ok   (volume_ok)
    );

    file_byte_stream file_byte_stream_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat       (beat),
        .data_phase (data_phase),
        .file_size  (hit.size),
        .outreq     (outreq),
        .outbyte    (outbyte)
    );

endmodule

`default_nettype wire

// ==== include/tb_disk_image.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// disk image of the current test case computed byte by byte
// 4 reserved sectors and 2 fats of 8 sectors each
// cluster numbers stay below 1024
// directory entries sit in the first sector of a root cluster
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_DISK_IMAGE_SVH
`define TB_DISK_IMAGE_SVH

localparam int img_reserved = 4;
localparam int img_fats     = 2;
localparam int img_spf      = 8;    // sectors per fat
localparam int img_data     = img_reserved + img_fats * img_spf;  // cluster 2 offset from the vbr

function automatic logic [7:0] le_byte(input logic [31:0] w, input int idx);
    return w[8*idx +: 8];
endfunction

// file data byte with every bit of sector number and offset folded in
function automatic logic [7:0] data_pattern(input logic [31:0] sec, input int off);
    logic [31:0] x;
    x = sec ^ 32'(off);
    return x[31:24] ^ x[23:16] ^ x[15:8] ^ x[7:0];
endfunction

function automatic logic [7:0] mbr_byte(input int off);
    if (off == 0)
        return 8'hFA;                   // boot code rather than a jump
    if (off == 'h1C2)
        return 8'h0C;                   // fat32 lba partition type
    if (off >= 'h1C6 && off <= 'h1C9)
        return le_byte(cur.part_start, off - 'h1C6);
    if (off == 'h1FE)
        return 8'h55;
    if (off == 'h1FF)
        return 8'hAA;
    return 8'h00;
endfunction

function automatic logic [7:0] vbr_byte(input int off);
    logic [63:0] fs_type;
    fs_type = cur.marker ? "FAT32   " : "        ";
    case (off)
        0: return 8'hEB;
        1: return 8'h58;
        2: return 8'h90;
        'h0B, 'h0C: return le_byte({16'd0, cur.bps}, off - 'h0B);
        'h0D: return cur.spc;
        'h0E, 'h0F: return le_byte(img_reserved, off - 'h0E);
        'h10: return 8'(img_fats);
        'h24, 'h25, 'h26, 'h27: return le_byte(img_spf, off - 'h24);
        'h2C, 'h2D, 'h2E, 'h2F: return le_byte(cur.root_chain[0], off - 'h2C);
        'h1FE: return 8'h55;
        'h1FF: return 8'hAA;
        default: ;
    endcase
    if (off >= 'h52 && off < 'h5A)
        return fs_type[8*('h59 - off) +: 8];    // file system type string
    return 8'h00;
endfunction

// next link of c in one chain or 0 when c is not part of it
function automatic logic [31:0] chain_link(input logic [2:0][31:0] chain,
                                           input logic [1:0] len, input logic [31:0] c);
    int i;
    for (i = 0; i < int'(len); i++) begin
        if (chain[i] == c)
            return (i == int'(len) - 1) ? 32'h0FFFFFFF : {4'hF, chain[i + 1][27:0]};
    end
    return 32'd0;
endfunction

function automatic logic [31:0] fat_value(input logic [31:0] c);
    logic [31:0] v;
    v = chain_link(cur.root_chain, cur.root_len, c);
    if (v == 32'd0)
        v = chain_link(cur.file_chain, cur.file_len, c);
    return v;
endfunction

function automatic logic [7:0] entry_byte(input logic [87:0] name, input logic [7:0] attr,
                                          input logic [31:0] clus, input logic [31:0] size,
                                          input int eo);
    if (eo < 11)
        return name[8*(10 - eo) +: 8];
    if (eo == 11)
        return attr;
    if (eo == 20 || eo == 21)
        return le_byte(clus, eo - 18);  // cluster high word
    if (eo == 26 || eo == 27)
        return le_byte(clus, eo - 26);
    if (eo >= 28)
        return le_byte(size, eo - 28);
    return 8'h00;
endfunction

function automatic logic [7:0] dir_byte(input int root_idx, input logic [31:0] sic,
                                        input int off);
    int slot;
    int eo;
    slot = off / 32;
    eo   = off % 32;
    if (sic != 32'd0)
        return 8'h00;
    if (root_idx == 0 && slot == 0)
        return entry_byte("DATA    BIN", 8'h08, 32'd0, 32'd0, eo);          // volume label
    if (root_idx == 0 && slot == 1)
        return entry_byte({8'hE5, "ATA    BIN"}, 8'h20, 32'd3, 32'd9, eo);  // deleted
    if (root_idx == 0 && slot == 2)
        return entry_byte("DATA    BIN", 8'h10, 32'd3, 32'd0, eo);          // subdirectory
    if (cur.present && root_idx == int'(cur.root_len) - 1 && slot == 3)
        return entry_byte("DATA    BIN", 8'h20, cur.file_chain[0], cur.size, eo);
    return 8'h00;
endfunction

function automatic logic [7:0] image_byte(input logic [31:0] sec, input int off);
    logic [31:0] vbr;
    logic [31:0] rel;
    logic [31:0] clus;
    logic [31:0] sic;
    int          i;
    vbr = cur.has_mbr ? cur.part_start : 32'd0;
    if (cur.has_mbr && sec == 32'd0)
        return mbr_byte(off);
    if (sec == vbr)
        return vbr_byte(off);
    if (sec < vbr + 32'(img_reserved))
        return 8'h00;
    rel = sec - vbr;
    if (rel < 32'(img_data)) begin
        // both fat copies hold the same table
        return le_byte(fat_value(((rel - 32'(img_reserved)) % 32'(img_spf)) * 32'd128
                                 + 32'(off / 4)), off % 4);
    end
    clus = (rel - 32'(img_data)) / 32'(cur.spc) + 32'd2;
    sic  = (rel - 32'(img_data)) % 32'(cur.spc);
    for (i = 0; i < int'(cur.root_len); i++) begin
        if (cur.root_chain[i] == clus)
            return dir_byte(i, sic, off);
    end
    return data_pattern(sec, off);
endfunction

`endif

// ==== tb/tb_fat32_file_reader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for fat32_file_reader with a modelled block device
// each table row is one disk image read after a fresh reset
// beats arrive with random gaps
// the run stops at the first error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_fat32_file_reader;

    localparam int num_cases       = 6;
    localparam int cycles_per_read = 2000;

    // element 0 of a chain is its first cluster and sits rightmost
    typedef struct packed {
        logic             has_mbr;
        logic [31:0]      part_start;
        logic [7:0]       spc;
        logic [15:0]      bps;
        logic             marker;
        logic             present;
        logic [31:0]      size;
        logic [1:0]       root_len;
        logic [2:0][31:0] root_chain;
        logic [1:0]       file_len;
        logic [2:0][31:0] file_chain;
        logic             exp_vok;
        logic             exp_found;
    } disk_case_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  read_done;
    fat_pkg::sector_beat_t beat;
    logic                  read_start;
    fat_pkg::sector_t      read_sector;
    fat_pkg::walk_state_e  state;
    logic                  volume_ok;
    logic                  file_found;
    logic                  outreq;
    logic [7:0]            outbyte;

    disk_case_t       cases [num_cases];
    disk_case_t       cur;
    logic [7:0]       exp_q [$];      // bytes still to come
    int               byte_idx;
    int               limit_cycles = 0;
    integer           seed;
    logic             in_flight = 1'b0;   // the device is serving a read
    fat_pkg::sector_t served_sector;

    `include "tb_disk_image.svh"

    always #4 clk = ~clk;

    fat32_file_reader #(
        .target_name ("DATA    BIN")
    ) fat32_file_reader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_done   (read_done),
        .beat        (beat),
        .read_start  (read_start),
        .read_sector (read_sector),
        .state       (state),
        .volume_ok   (volume_ok),
        .file_found  (file_found),
        .outreq      (outreq),
        .outbyte     (outbyte)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("mismatch at time %0t: byte %0d is %h, expected %h",
                                        $time, byte_idx, got, exp));
        else
            byte_idx++;
    endtask

    task automatic verify_end_state(input fat_pkg::walk_state_e got_state, input logic got_vok,
                                    input logic got_found, input logic exp_vok,
                                    input logic exp_found);
        if (got_state !== fat_pkg::DONE || got_vok !== exp_vok || got_found !== exp_found)
            stop_with_failure($sformatf(
                "mismatch at time %0t: state %s volume_ok %b file_found %b, expected DONE %b %b",
                $time, got_state.name(), got_vok, got_found, exp_vok, exp_found));
    endtask

    task automatic load_cases();
        cases[0] = '{has_mbr: 1'b1, part_start: 32'd64, spc: 8'd2, bps: 16'd512,
                     marker: 1'b1, present: 1'b1, size: 32'd2660,
                     root_len: 2'd1, root_chain: {32'd0, 32'd0, 32'd2},
                     file_len: 2'd3, file_chain: {32'd5, 32'd130, 32'd3},
                     exp_vok: 1'b1, exp_found: 1'b1};
        cases[1] = '{has_mbr: 1'b0, part_start: 32'd0, spc: 8'd2, bps: 16'd512,
                     marker: 1'b1, present: 1'b1, size: 32'd2660,
                     root_len: 2'd1, root_chain: {32'd0, 32'd0, 32'd2},
                     file_len: 2'd3, file_chain: {32'd5, 32'd130, 32'd3},
                     exp_vok: 1'b1, exp_found: 1'b1};
        // root directory over clusters 2 and 9
        cases[2] = '{has_mbr: 1'b1, part_start: 32'd32, spc: 8'd1, bps: 16'd512,
                     marker: 1'b1, present: 1'b1, size: 32'd1300,
                     root_len: 2'd2, root_chain: {32'd0, 32'd9, 32'd2},
                     file_len: 2'd3, file_chain: {32'd6, 32'd4, 32'd3},
                     exp_vok: 1'b1, exp_found: 1'b1};
        cases[3] = '{has_mbr: 1'b1, part_start: 32'd64, spc: 8'd2, bps: 16'd512,
                     marker: 1'b1, present: 1'b0, size: 32'd2660,
                     root_len: 2'd1, root_chain: {32'd0, 32'd0, 32'd2},
                     file_len: 2'd3, file_chain: {32'd5, 32'd130, 32'd3},
                     exp_vok: 1'b1, exp_found: 1'b0};
        cases[4] = '{has_mbr: 1'b1, part_start: 32'd64, spc: 8'd2, bps: 16'd1024,
                     marker: 1'b1, present: 1'b1, size: 32'd2660,
                     root_len: 2'd1, root_chain: {32'd0, 32'd0, 32'd2},
                     file_len: 2'd3, file_chain: {32'd5, 32'd130, 32'd3},
                     exp_vok: 1'b0, exp_found: 1'b0};
        cases[5] = '{has_mbr: 1'b0, part_start: 32'd0, spc: 8'd2, bps: 16'd512,
                     marker: 1'b0, present: 1'b1, size: 32'd2660,
                     root_len: 2'd1, root_chain: {32'd0, 32'd0, 32'd2},
                     file_len: 2'd3, file_chain: {32'd5, 32'd130, 32'd3},
                     exp_vok: 1'b0, exp_found: 1'b0};
    endtask

    // upper bound of sector reads counting boot sectors and each cluster with its fat lookup
    function automatic int reads_of(input disk_case_t dc);
        return 2 + (int'(dc.root_len) + int'(dc.file_len)) * (int'(dc.spc) + 1);
    endfunction

    task automatic build_expected();
        logic [31:0] base;
        logic [31:0] sec;
        int          i;
        int          s;
        int          off;
        exp_q.delete();
        base = (cur.has_mbr ? cur.part_start : 32'd0) + 32'(img_data);
        if (cur.exp_found) begin
            for (i = 0; i < int'(cur.file_len); i++) begin
                for (s = 0; s < int'(cur.spc); s++) begin
                    sec = base + (cur.file_chain[i] - 32'd2) * 32'(cur.spc) + 32'(s);
                    for (off = 0; off < fat_pkg::sector_bytes; off++) begin
                        if (exp_q.size() < int'(cur.size))
                            exp_q.push_back(data_pattern(sec, off));
                    end
                end
            end
        end
    endtask

    // 512 beats with random gaps and read_done at least two cycles after the last one
    task automatic serve_read(input fat_pkg::sector_t sec);
        int gap;
        int off;
        @(posedge clk);
        served_sector = sec;
        in_flight     = 1'b1;
        for (off = 0; off < fat_pkg::sector_bytes; off++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                #1 beat = '0;
                @(posedge clk);
            end
            #1 beat = '{valid: 1'b1, offset: 9'(off), data: image_byte(sec, off)};
            @(posedge clk);
        end
        #1 beat = '0;
        repeat (2) @(posedge clk);
        #1 read_done = 1'b1;
        @(posedge clk);
        #1 read_done = 1'b0;
        in_flight = 1'b0;
    endtask

    always begin : device_model
        @(negedge clk);
        if (rst_n === 1'b1 && read_start === 1'b1)
            serve_read(read_sector);
    end

    // the reader keeps read_sector and sends no read_start until read_done
    always @(negedge clk) begin
        if (rst_n === 1'b1 && in_flight
                && (read_start !== 1'b0 || read_sector !== served_sector))
            stop_with_failure($sformatf(
                "read_start or read_sector changed at time %0t while sector %0d was read",
                $time, served_sector));
    end

    always @(negedge clk) begin
        if (rst_n === 1'b1 && outreq === 1'b1) begin
            if (exp_q.size() == 0)
                stop_with_failure($sformatf("byte %0d came out beyond the file size", byte_idx));
            else
                compare_byte(outbyte, exp_q.pop_front());
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        stop_with_failure($sformatf("timeout, the run did not finish in %0d cycles",
                                    limit_cycles));
    end

    initial begin : main
        int c;
        int reads;
        seed      = 32'h19d151d7;
        rst_n     = 1'b0;
        read_done = 1'b0;
        beat      = '0;
        byte_idx  = 0;
        load_cases();
        reads = 0;
        for (c = 0; c < num_cases; c++)
            reads += reads_of(cases[c]);
        limit_cycles = reads * cycles_per_read;
        for (c = 0; c < num_cases; c++) begin
            cur = cases[c];
            build_expected();
            byte_idx = 0;
            @(posedge clk);
            #1 rst_n = 1'b0;
            repeat (5) @(posedge clk);
            #1 rst_n = 1'b1;
            while (state !== fat_pkg::DONE)
                @(negedge clk);
            repeat (8) @(negedge clk);      // a late byte would still show up
            verify_end_state(state, volume_ok, file_found, cur.exp_vok, cur.exp_found);
            if (exp_q.size() != 0)
                stop_with_failure($sformatf("case %0d ended with %0d file bytes missing",
                                            c, exp_q.size()));
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
design/fat_pkg.sv
design/boot_sector_parser.sv
design/dir_entry_matcher.sv
design/cluster_walker.sv
design/file_byte_stream.sv
design/fat32_file_reader.sv
tb/tb_fat32_file_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run, the simulation log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_fat32_file_reader \
    -f project.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
